// ==== rtl/idu_pkg.sv ====
`default_nettype none

package idu_pkg;

    typedef logic [31:0] inst_word_t;
    typedef logic [31:0] data_word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [11:0] csr_addr_t;

    // major opcodes, inst[6:0]
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // inst[31:20] of the privileged system instructions
    localparam csr_addr_t SYS_ECALL  = 12'h000;
    localparam csr_addr_t SYS_EBREAK = 12'h001;
    localparam csr_addr_t SYS_MRET   = 12'h302;
    localparam csr_addr_t SYS_WFI    = 12'h105;

    typedef enum logic [1:0] {
        SET_NULL, SET_RV32I, SET_RV32M
    } inst_set_e;

    typedef enum logic [2:0] {
        TYPE_NULL, TYPE_R, TYPE_I, TYPE_S, TYPE_B, TYPE_U, TYPE_J, TYPE_CSR
    } inst_type_e;

    typedef enum logic [4:0] {
        FUNC_NULL, FUNC_LOAD, FUNC_STORE, FUNC_ADD, FUNC_SUB, FUNC_SLL, FUNC_SLT,
        FUNC_XOR, FUNC_SRL, FUNC_SRA, FUNC_OR, FUNC_AND, FUNC_LUI, FUNC_AUIPC,
        FUNC_MUL, FUNC_DIV, FUNC_REM, FUNC_B, FUNC_JAL, FUNC_JALR,
        FUNC_ECALL, FUNC_EBREAK, FUNC_MRET, FUNC_WFI,
        FUNC_CSRRW, FUNC_CSRRS, FUNC_CSRRC
    } func_op_e;

    typedef enum logic [1:0] {
        BUF_EMPTY, BUF_ONE, BUF_TWO
    } buf_state_e;

    typedef struct packed {
        logic imm;
        logic byt;    // byte access
        logic half;
        logic unsign;
        logic u1;     // operand 1 unsigned
        logic u2;     // operand 2 unsigned
        logic high;
        logic eq;
        logic ne;
        logic lt;
        logic gt;
    } func_sfx_t;

    localparam func_sfx_t SFX_NONE   = 11'h000;
    localparam func_sfx_t SFX_IMM    = 11'h400;
    localparam func_sfx_t SFX_BYTE   = 11'h200;
    localparam func_sfx_t SFX_HALF   = 11'h100;
    localparam func_sfx_t SFX_UNSIGN = 11'h080;
    localparam func_sfx_t SFX_U1     = 11'h040;
    localparam func_sfx_t SFX_U2     = 11'h020;
    localparam func_sfx_t SFX_HIGH   = 11'h010;
    localparam func_sfx_t SFX_EQ     = 11'h008;
    localparam func_sfx_t SFX_NE     = 11'h004;
    localparam func_sfx_t SFX_LT     = 11'h002;
    localparam func_sfx_t SFX_GT     = 11'h001;

    typedef struct packed {
        func_op_e  op;
        func_sfx_t sfx;
    } inst_func_t;

    typedef struct packed {
        logic is_ecall;
        logic is_ebreak;
        logic is_mret;
        logic is_wfi;
        logic is_csrrx;   // register source form
        logic is_csrri;   // immediate source form
    } sys_flags_t;

    typedef struct packed {
        inst_set_e  set;
        inst_type_e itype;
        inst_func_t func;
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        reg_addr_t  rd;
        logic       rd_vld;
        data_word_t uimm;
        csr_addr_t  csr;
    } dec_pkt_t;

endpackage

`default_nettype wire

// ==== rtl/idu_class.sv ====
`default_nettype none

module idu_class import idu_pkg::*; (
    input  inst_word_t inst_i,
    output inst_set_e  set_o,
    output inst_type_e type_o,
    output sys_flags_t sys_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       rs1_zero;
    logic       funct3_zero;
    logic       rd_zero;
    csr_addr_t  sys_imm;

    assign opcode      = inst_i[6:0];
    assign funct3      = inst_i[14:12];
    assign rs1_zero    = (inst_i[19:15] == 5'd0);
    assign funct3_zero = (funct3 == 3'd0);
    assign rd_zero     = (inst_i[11:7] == 5'd0);
    assign sys_imm     = inst_i[31:20];

    always_comb begin
        sys_o.is_ecall  = (sys_imm == SYS_ECALL) && rs1_zero && funct3_zero && rd_zero;
        sys_o.is_ebreak = (sys_imm == SYS_EBREAK) && rs1_zero && funct3_zero && rd_zero;
        sys_o.is_mret   = (sys_imm == SYS_MRET) && rs1_zero && funct3_zero && rd_zero;
        sys_o.is_wfi    = (sys_imm == SYS_WFI) && rs1_zero && funct3_zero; // rd not checked
        sys_o.is_csrrx  = !funct3[2] && !funct3_zero;
        sys_o.is_csrri  = funct3[2];
    end

    always_comb begin
        case (opcode)
            OPC_LOAD, OPC_OPIMM, OPC_JALR: begin
                set_o  = SET_RV32I;
                type_o = TYPE_I;
            end
            OPC_LUI, OPC_AUIPC: begin
                set_o  = SET_RV32I;
                type_o = TYPE_U;
            end
            OPC_STORE: begin
                set_o  = SET_RV32I;
                type_o = TYPE_S;
            end
            OPC_OP: begin
                set_o  = inst_i[25] ? SET_RV32M : SET_RV32I; // funct7[0] selects muldiv
                type_o = TYPE_R;
            end
            OPC_BRANCH: begin
                set_o  = SET_RV32I;
                type_o = TYPE_B;
            end
            OPC_JAL: begin
                set_o  = SET_RV32I;
                type_o = TYPE_J;
            end
            OPC_SYSTEM: begin
                set_o  = SET_RV32I;
                type_o = TYPE_CSR;
            end
            default: begin
                set_o  = SET_NULL;   // fp and unknown opcodes
                type_o = TYPE_NULL;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/idu_func.sv ====
`default_nettype none

module idu_func import idu_pkg::*; (
    input  inst_word_t inst_i,
    input  sys_flags_t sys_i,
    output inst_func_t func_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];

    always_comb begin
        case (opcode)
            OPC_LOAD: begin
                case (funct3)
                    3'b000:  func_o = {FUNC_LOAD, SFX_IMM | SFX_BYTE};
                    3'b001:  func_o = {FUNC_LOAD, SFX_IMM | SFX_HALF};
                    3'b010:  func_o = {FUNC_LOAD, SFX_IMM};
                    3'b100:  func_o = {FUNC_LOAD, SFX_IMM | SFX_BYTE | SFX_UNSIGN};
                    3'b101:  func_o = {FUNC_LOAD, SFX_IMM | SFX_HALF | SFX_UNSIGN};
                    default: func_o = '0;
                endcase
            end
            OPC_OPIMM: begin
                case (funct3)
                    3'b000:  func_o = {FUNC_ADD, SFX_IMM};
                    3'b001:  func_o = {FUNC_SLL, SFX_IMM};
                    3'b010:  func_o = {FUNC_SLT, SFX_IMM};
                    3'b011:  func_o = {FUNC_SLT, SFX_IMM | SFX_UNSIGN};
                    3'b100:  func_o = {FUNC_XOR, SFX_IMM};
                    3'b101:  func_o = {(funct7[5] ? FUNC_SRA : FUNC_SRL), SFX_IMM};
                    3'b110:  func_o = {FUNC_OR, SFX_IMM};
                    default: func_o = {FUNC_AND, SFX_IMM};
                endcase
            end
            OPC_STORE: begin
                case (funct3)
                    3'b000:  func_o = {FUNC_STORE, SFX_IMM | SFX_BYTE};
                    3'b001:  func_o = {FUNC_STORE, SFX_IMM | SFX_HALF};
                    3'b010:  func_o = {FUNC_STORE, SFX_IMM};
                    default: func_o = '0;
                endcase
            end
            OPC_OP: begin
                if (funct7[0]) begin
                    case (funct3)
                        3'b000:  func_o = {FUNC_MUL, SFX_NONE};
                        3'b001:  func_o = {FUNC_MUL, SFX_HIGH};                     // mulh
                        3'b010:  func_o = {FUNC_MUL, SFX_U2 | SFX_HIGH};            // mulhsu
                        3'b011:  func_o = {FUNC_MUL, SFX_U1 | SFX_U2 | SFX_HIGH};
                        3'b100:  func_o = {FUNC_DIV, SFX_NONE};
                        3'b101:  func_o = {FUNC_DIV, SFX_U1 | SFX_U2};
                        3'b110:  func_o = {FUNC_REM, SFX_NONE};
                        default: func_o = {FUNC_REM, SFX_U1 | SFX_U2};
                    endcase
                end else begin
                    case (funct3)
                        3'b000:  func_o = {(funct7[5] ? FUNC_SUB : FUNC_ADD), SFX_NONE};
                        3'b001:  func_o = {FUNC_SLL, SFX_NONE};
                        3'b010:  func_o = {FUNC_SLT, SFX_NONE};
                        3'b011:  func_o = {FUNC_SLT, SFX_UNSIGN};
                        3'b100:  func_o = {FUNC_XOR, SFX_NONE};
                        3'b101:  func_o = {(funct7[5] ? FUNC_SRA : FUNC_SRL), SFX_NONE};
                        3'b110:  func_o = {FUNC_OR, SFX_NONE};
                        default: func_o = {FUNC_AND, SFX_NONE};
                    endcase
                end
            end
            OPC_LUI:   func_o = {FUNC_LUI, SFX_IMM};
            OPC_AUIPC: func_o = {FUNC_AUIPC, SFX_NONE};  // no imm flag on auipc
            OPC_BRANCH: begin
                case (funct3)
                    3'b000:  func_o = {FUNC_B, SFX_EQ};
                    3'b001:  func_o = {FUNC_B, SFX_NE};
                    3'b100:  func_o = {FUNC_B, SFX_LT};
                    3'b101:  func_o = {FUNC_B, SFX_GT | SFX_EQ};
                    3'b110:  func_o = {FUNC_B, SFX_LT | SFX_UNSIGN};
                    3'b111:  func_o = {FUNC_B, SFX_GT | SFX_EQ | SFX_UNSIGN};
                    default: func_o = '0;
                endcase
            end
            OPC_JAL:  func_o = {FUNC_JAL, SFX_NONE};
            OPC_JALR: func_o = {FUNC_JALR, SFX_NONE};
            OPC_SYSTEM: begin
                case (funct3)
                    3'b000: begin
                        case ({sys_i.is_ecall, sys_i.is_ebreak, sys_i.is_mret, sys_i.is_wfi})
                            4'b1000: func_o = {FUNC_ECALL, SFX_NONE};
                            4'b0100: func_o = {FUNC_EBREAK, SFX_NONE};
                            4'b0010: func_o = {FUNC_MRET, SFX_NONE};
                            4'b0001: func_o = {FUNC_WFI, SFX_NONE};
                            default: func_o = '0;   // no exact match
                        endcase
                    end
                    3'b001:  func_o = {FUNC_CSRRW, SFX_NONE};
                    3'b010:  func_o = {FUNC_CSRRS, SFX_NONE};
                    3'b011:  func_o = {FUNC_CSRRC, SFX_NONE};
                    3'b101:  func_o = {FUNC_CSRRW, SFX_IMM};
                    3'b110:  func_o = {FUNC_CSRRS, SFX_IMM};
                    3'b111:  func_o = {FUNC_CSRRC, SFX_IMM};
                    default: func_o = '0;
                endcase
            end
            default: func_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/idu_imm.sv ====
`default_nettype none

module idu_imm import idu_pkg::*; (
    input  inst_word_t inst_i,
    input  inst_type_e type_i,
    input  sys_flags_t sys_i,
    output data_word_t uimm_o,
    output csr_addr_t  csr_o
);

    logic [11:0] imm12_i;
    logic [11:0] imm12_s;
    logic [11:0] imm12_b;
    logic [19:0] imm20_u;
    logic [19:0] imm20_j;
    logic [4:0]  uimm5;

    assign imm12_i = inst_i[31:20];
    assign imm12_s = {inst_i[31:25], inst_i[11:7]};
    assign imm12_b = {inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8]};    // bit 0 implied
    assign imm20_u = inst_i[31:12];
    assign imm20_j = {inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21]};
    assign uimm5   = inst_i[19:15];   // rs1 field of csr*i

    always_comb begin
        case (type_i)
            TYPE_I: begin
                uimm_o = {20'd0, imm12_i};
            end
            TYPE_S: begin
                uimm_o = {20'd0, imm12_s};
            end
            TYPE_B: begin
                uimm_o = {20'd0, imm12_b};
            end
            TYPE_U: begin
                uimm_o = {12'd0, imm20_u};
            end
            TYPE_J: begin
                uimm_o = {12'd0, imm20_j};
            end
            TYPE_CSR: begin
                uimm_o = sys_i.is_csrri ? {27'd0, uimm5} : '0;
            end
            default: begin
                uimm_o = '0;   // R and null
            end
        endcase
    end

    assign csr_o = (type_i == TYPE_CSR) ? inst_i[31:20] : '0;

endmodule

`default_nettype wire

// ==== rtl/idu_operand.sv ====
`default_nettype none

module idu_operand import idu_pkg::*; (
    input  inst_word_t inst_i,
    input  inst_set_e  set_i,
    input  inst_type_e type_i,
    input  inst_func_t func_i,
    input  sys_flags_t sys_i,
    input  data_word_t uimm_i,
    input  csr_addr_t  csr_i,
    output dec_pkt_t   pkt_o
);

    // {rs1, rs2, rd, imm, csr}
    logic [4:0] vld;

    always_comb begin
        case (type_i)
            TYPE_R:   vld = 5'b11100;
            TYPE_I:   vld = 5'b10110;
            TYPE_S:   vld = 5'b11010;
            TYPE_B:   vld = 5'b11010;
            TYPE_U:   vld = 5'b00110;
            TYPE_J:   vld = 5'b00110;
            TYPE_CSR: vld = {sys_i.is_csrrx, 1'b0, 1'b1, sys_i.is_csrri, 1'b1};
            default:  vld = 5'b00000;
        endcase
    end

    always_comb begin
        pkt_o.set    = set_i;
        pkt_o.itype  = type_i;
        pkt_o.func   = func_i;
        pkt_o.rs1    = vld[4] ? inst_i[19:15] : '0;
        pkt_o.rs2    = vld[3] ? inst_i[24:20] : '0;
        pkt_o.rd     = vld[2] ? inst_i[11:7] : '0;
        pkt_o.rd_vld = vld[2];
        pkt_o.uimm   = vld[1] ? uimm_i : '0;
        pkt_o.csr    = vld[0] ? csr_i : '0;
    end

endmodule

`default_nettype wire

// ==== rtl/idu_out_buf.sv ====
`default_nettype none

module idu_out_buf import idu_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_i,
    input  logic     in_valid_i,
    input  dec_pkt_t in_pkt_i,
    output logic     in_ready_o,
    output logic     out_valid_o,
    output dec_pkt_t out_pkt_o,
    input  logic     out_ready_i
);

    buf_state_e state;
    dec_pkt_t   head;   // drives the output
    dec_pkt_t   tail;   // second entry when two are held
    logic       push;
    logic       pop;

    assign in_ready_o  = (state != BUF_TWO);
    assign out_valid_o = (state != BUF_EMPTY);
    assign out_pkt_o   = head;
    assign push        = in_valid_i && in_ready_o;
    assign pop         = out_valid_o && out_ready_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state <= BUF_EMPTY;
        end else begin
            case (state)
                BUF_EMPTY: state <= push ? BUF_ONE : BUF_EMPTY;
                BUF_ONE: begin
                    if (push && !pop) begin
                        state <= BUF_TWO;
                    end else if (pop && !push) begin
                        state <= BUF_EMPTY;
                    end
                end
                BUF_TWO:   state <= pop ? BUF_ONE : BUF_TWO;
                default:   state <= BUF_EMPTY;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state == BUF_TWO) begin
            if (pop) begin
                head <= tail;
            end
        end else if (push && (state == BUF_EMPTY || pop)) begin
            head <= in_pkt_i;   // goes straight to the front
        end
        if (push && state == BUF_ONE && !pop) begin
            tail <= in_pkt_i;
        end
    end

    ast_hold_stalled: assert property (@(posedge clk_i) disable iff (rst_i)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_pkt_o))
        else $error("idu_out_buf: packet changed while stalled");

    ast_src_held: assert property (@(posedge clk_i) disable iff (rst_i)
        in_valid_i && !in_ready_o |=> in_valid_i && $stable(in_pkt_i))
        else $error("idu_out_buf: refused packet dropped or changed by the source");

endmodule

`default_nettype wire

// ==== rtl/idu_top.sv ====
`default_nettype none

module idu_top import idu_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_i,
    input  logic       in_valid_i,
    input  inst_word_t in_inst_i,
    output logic       in_ready_o,
    output logic       out_valid_o,
    output dec_pkt_t   out_pkt_o,
    input  logic       out_ready_i
);

    inst_set_e  set;
    inst_type_e itype;
    sys_flags_t sys;
    inst_func_t func;
    data_word_t uimm;
    csr_addr_t  csr;
    dec_pkt_t   pkt;   // combinational decode result

    idu_class u_class (
        .inst_i (in_inst_i),
        .set_o  (set),
        .type_o (itype),
        .sys_o  (sys)
    );

    idu_func u_func (
        .inst_i (in_inst_i),
        .sys_i  (sys),
        .func_o (func)
    );

    idu_imm u_imm (
        .inst_i (in_inst_i),
        .type_i (itype),
        .sys_i  (sys),
        .uimm_o (uimm),
        .csr_o  (csr)
    );

    idu_operand u_operand (
        .inst_i (in_inst_i),
        .set_i  (set),
        .type_i (itype),
        .func_i (func),
        .sys_i  (sys),
        .uimm_i (uimm),
        .csr_i  (csr),
        .pkt_o  (pkt)
    );

    idu_out_buf u_out_buf (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .in_valid_i  (in_valid_i),
        .in_pkt_i    (pkt),
        .in_ready_o  (in_ready_o),
        .out_valid_o (out_valid_o),
        .out_pkt_o   (out_pkt_o),
        .out_ready_i (out_ready_i)
    );

endmodule

`default_nettype wire

// ==== bench/idu_model.svh ====
`ifndef IDU_MODEL_SVH
`define IDU_MODEL_SVH

// base alu operation per funct3, before the funct7 alternates
localparam func_op_e ALU_OPS [8] = '{FUNC_ADD, FUNC_SLL, FUNC_SLT, FUNC_SLT,
                                     FUNC_XOR, FUNC_SRL, FUNC_OR, FUNC_AND};

function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
endfunction

// expected decode packet for one instruction word
function automatic dec_pkt_t ref_decode(input inst_word_t w);
    dec_pkt_t   p;
    logic [2:0] f3;
    logic       sys_zero;
    func_op_e   op;
    func_sfx_t  sx;
    logic       v_rs1;
    logic       v_rs2;
    logic       v_imm;
    data_word_t imm;
    p        = '0;
    f3       = w[14:12];
    sys_zero = (w[19:15] == 5'd0) && (f3 == 3'd0);
    op       = FUNC_NULL;
    sx       = '0;
    case (w[6:0])
        OPC_LOAD: begin
            p.itype = TYPE_I;
            if (f3 != 3'd3 && f3 < 3'd6) begin
                op        = FUNC_LOAD;
                sx.imm    = 1'b1;
                sx.byt    = (f3[1:0] == 2'd0);
                sx.half   = (f3[1:0] == 2'd1);
                sx.unsign = f3[2];
            end
        end
        OPC_STORE: begin
            p.itype = TYPE_S;
            if (f3 < 3'd3) begin
                op      = FUNC_STORE;
                sx.imm  = 1'b1;
                sx.byt  = (f3 == 3'd0);
                sx.half = (f3 == 3'd1);
            end
        end
        OPC_OPIMM, OPC_OP: begin
            p.itype = (w[6:0] == OPC_OP) ? TYPE_R : TYPE_I;
            sx.imm  = (w[6:0] == OPC_OPIMM);
            if (w[6:0] == OPC_OP && w[25]) begin
                op      = f3[2] ? (f3[1] ? FUNC_REM : FUNC_DIV) : FUNC_MUL;
                sx.high = !f3[2] && (f3 != 3'd0);
                sx.u2   = f3[2] ? f3[0] : f3[1];
                sx.u1   = f3[2] ? f3[0] : (f3 == 3'd3);
            end else begin
                op        = ALU_OPS[f3];
                sx.unsign = (f3 == 3'd3);
                if (w[30] && f3 == 3'd5) begin
                    op = FUNC_SRA;
                end
                if (w[30] && f3 == 3'd0 && w[6:0] == OPC_OP) begin
                    op = FUNC_SUB;
                end
            end
        end
        OPC_LUI, OPC_AUIPC: begin
            p.itype = TYPE_U;
            op      = (w[6:0] == OPC_LUI) ? FUNC_LUI : FUNC_AUIPC;
            sx.imm  = (w[6:0] == OPC_LUI);
        end
        OPC_JAL: begin
            p.itype = TYPE_J;
            op      = FUNC_JAL;
        end
        OPC_JALR: begin
            p.itype = TYPE_I;
            op      = FUNC_JALR;
        end
        OPC_BRANCH: begin
            p.itype = TYPE_B;
            if (f3[2:1] != 2'b01) begin
                op        = FUNC_B;
                sx.eq     = (f3 == 3'd0) || (f3[2] && f3[0]);
                sx.ne     = (f3 == 3'd1);
                sx.lt     = f3[2] && !f3[0];
                sx.gt     = f3[2] && f3[0];
                sx.unsign = f3[2] && f3[1];
            end
        end
        OPC_SYSTEM: begin
            p.itype = TYPE_CSR;
            if (f3[1:0] != 2'd0) begin
                op = (f3[1:0] == 2'd1) ? FUNC_CSRRW : (f3[1:0] == 2'd2) ? FUNC_CSRRS : FUNC_CSRRC;
                sx.imm = f3[2];
            end else if (sys_zero && w[31:20] == SYS_WFI) begin
                op = FUNC_WFI;   // rd is free for wfi
            end else if (sys_zero && w[11:7] == 5'd0) begin
                case (w[31:20])
                    SYS_ECALL:  op = FUNC_ECALL;
                    SYS_EBREAK: op = FUNC_EBREAK;
                    SYS_MRET:   op = FUNC_MRET;
                    default:    op = FUNC_NULL;
                endcase
            end
        end
        default: op = FUNC_NULL;   // fp and junk opcodes
    endcase
    p.set = (p.itype == TYPE_NULL) ? SET_NULL :
            (p.itype == TYPE_R && w[25]) ? SET_RV32M : SET_RV32I;
    v_rs1    = p.itype inside {TYPE_R, TYPE_I, TYPE_S, TYPE_B} ||
               (p.itype == TYPE_CSR && f3 != 3'd0 && !f3[2]);
    v_rs2    = p.itype inside {TYPE_R, TYPE_S, TYPE_B};
    p.rd_vld = p.itype inside {TYPE_R, TYPE_I, TYPE_U, TYPE_J, TYPE_CSR};
    v_imm    = p.itype inside {TYPE_I, TYPE_S, TYPE_B, TYPE_U, TYPE_J} ||
               (p.itype == TYPE_CSR && f3[2]);
    case (p.itype)
        TYPE_I:   imm = {20'd0, w[31:20]};
        TYPE_S:   imm = {20'd0, w[31:25], w[11:7]};
        TYPE_B:   imm = {20'd0, w[31], w[7], w[30:25], w[11:8]};
        TYPE_U:   imm = {12'd0, w[31:12]};
        TYPE_J:   imm = {12'd0, w[31], w[19:12], w[20], w[30:21]};
        TYPE_CSR: imm = {27'd0, w[19:15]};
        default:  imm = '0;
    endcase
    p.func.op  = op;
    p.func.sfx = sx;
    p.rs1      = v_rs1 ? w[19:15] : '0;
    p.rs2      = v_rs2 ? w[24:20] : '0;
    p.rd       = p.rd_vld ? w[11:7] : '0;
    p.uimm     = v_imm ? imm : '0;
    p.csr      = (p.itype == TYPE_CSR) ? w[31:20] : '0;
    return p;
endfunction

`endif

// ==== bench/idu_tb.sv ====
`default_nettype none

module idu_tb import idu_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_RV32I = 400;
    localparam int N_MSYS  = 300;
    localparam int N_DROP  = 150;
    localparam int N_PRESS = 500;
    localparam int N_THRU  = 300;
    localparam int WATCHDOG_CYCLES = (N_RV32I + N_MSYS + N_DROP + N_PRESS + N_THRU) * 8 + 100;

    localparam int K_RV32I = 0;
    localparam int K_MSYS  = 1;
    localparam int K_DROP  = 2;
    localparam int K_MIX   = 3;

    localparam logic [6:0] RV32I_OPCS [9] = '{OPC_LOAD, OPC_OPIMM, OPC_AUIPC, OPC_STORE,
        OPC_OP, OPC_LUI, OPC_BRANCH, OPC_JALR, OPC_JAL};
    localparam logic [6:0] FP_OPCS [7] = '{7'b0000111, 7'b0100111, 7'b1000011,
        7'b1000111, 7'b1001011, 7'b1001111, 7'b1010011};

    `include "idu_model.svh"

    logic        clk       = 1'b0;
    logic        rst       = 1'b1;
    logic        in_valid  = 1'b0;
    inst_word_t  in_inst   = '0;
    logic        out_ready = 1'b0;
    logic        in_ready;
    logic        out_valid;
    dec_pkt_t    out_pkt;

    dec_pkt_t    exp_q[$];
    dec_pkt_t    exp_head  = '0;   // head of exp_q as seen before the edge
    int          held      = 0;
    int          accepted  = 0;
    int          taken     = 0;
    int          errors    = 0;
    int          tests     = 0;
    logic        thru_mode = 1'b0;
    logic [31:0] rng_state;

    idu_top u_idu_top (
        .clk_i       (clk),
        .rst_i       (rst),
        .in_valid_i  (in_valid),
        .in_inst_i   (in_inst),
        .in_ready_o  (in_ready),
        .out_valid_o (out_valid),
        .out_pkt_o   (out_pkt),
        .out_ready_i (out_ready)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] next_rand();
        rng_state = lcg_step(rng_state);
        return rng_state;
    endfunction

    function automatic logic chance(input int pct);
        return (next_rand() % 32'd100) < 32'(pct);
    endfunction

    function automatic logic known_opcode(input logic [6:0] opc);
        logic hit;
        hit = (opc == OPC_SYSTEM);
        for (int i = 0; i < 9; i++) begin
            if (RV32I_OPCS[i] == opc) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    function automatic inst_word_t gen_word(input int kind);
        logic [31:0] r;
        inst_word_t  w;
        int          k;
        r = next_rand();
        w = next_rand();
        k = kind;
        if (kind == K_MIX) begin
            k = (r[12:10] < 3'd4) ? K_RV32I : (r[11] ? K_DROP : K_MSYS);
        end
        case (k)
            K_RV32I: begin
                w[6:0] = RV32I_OPCS[r[3:0] % 4'd9];
                if (w[6:0] == OPC_OP) begin
                    w[25] = 1'b0;
                end
            end
            K_MSYS: begin
                if (r[4]) begin
                    w[6:0] = OPC_OP;
                    w[25]  = 1'b1;
                end else begin
                    w[6:0] = OPC_SYSTEM;
                    case (r[7:5])
                        3'd0: w[31:7] = {SYS_ECALL, 13'd0};
                        3'd1: w[31:7] = {SYS_EBREAK, 13'd0};
                        3'd2: w[31:7] = {SYS_MRET, 13'd0};
                        3'd3: w[31:12] = {SYS_WFI, 8'd0};   // any rd
                        3'd4: begin
                            w[31:20] = r[8] ? SYS_MRET : SYS_ECALL;
                            w[14:12] = 3'd0;   // near miss with rs1 or rd mostly nonzero
                        end
                        default: w[31:20] = r[31:20];   // csr forms
                    endcase
                end
            end
            default: begin
                if (r[4]) begin
                    w[6:0] = FP_OPCS[r[7:5] % 3'd7];
                end else begin
                    w[6:0] = r[22:16];
                    while (known_opcode(w[6:0])) begin
                        w[6:0] = w[6:0] + 7'd1;
                    end
                end
            end
        endcase
        return w;
    endfunction

    task automatic field_diff(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got != exp) begin
            $display("[FAIL] out_pkt_o.%s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic show_pkt_diff(input dec_pkt_t got, input dec_pkt_t exp);
        field_diff("set", 32'(got.set), 32'(exp.set));
        field_diff("itype", 32'(got.itype), 32'(exp.itype));
        field_diff("func", 32'(got.func), 32'(exp.func));
        field_diff("rs1", 32'(got.rs1), 32'(exp.rs1));
        field_diff("rs2", 32'(got.rs2), 32'(exp.rs2));
        field_diff("rd", 32'(got.rd), 32'(exp.rd));
        field_diff("rd_vld", 32'(got.rd_vld), 32'(exp.rd_vld));
        field_diff("uimm", got.uimm, exp.uimm);
        field_diff("csr", 32'(got.csr), 32'(exp.csr));
    endtask

    // pops handled before pushes within one edge
    always @(posedge clk) begin
        if (rst) begin
            exp_q.delete();
        end else begin
            if (out_valid && out_ready && exp_q.size() > 0) begin
                void'(exp_q.pop_front());
                taken++;
            end
            if (in_valid && in_ready) begin
                exp_q.push_back(ref_decode(in_inst));
                accepted++;
            end
        end
        exp_head <= (exp_q.size() > 0) ? exp_q[0] : '0;
        held     <= exp_q.size();
    end

    ast_reset_idle: assert property (@(posedge clk)
        (rst && $past(rst)) || $fell(rst) |-> !out_valid && in_ready)
        else begin
            errors++;
            $display("[FAIL] out_valid_o 0x%h in_ready_o 0x%h around reset",
                $sampled(out_valid), $sampled(in_ready));
        end

    ast_pkt_match: assert property (@(posedge clk) disable iff (rst)
        out_valid && out_ready |-> out_pkt == exp_head)
        else begin
            errors++;
            show_pkt_diff($sampled(out_pkt), $sampled(exp_head));
        end

    ast_no_extra: assert property (@(posedge clk) disable iff (rst)
        out_valid && out_ready |-> held != 0)
        else begin
            errors++;
            $display("a packet was taken with no instruction outstanding");
        end

    ast_ready_full: assert property (@(posedge clk) disable iff (rst)
        in_ready == (held < 2))
        else begin
            errors++;
            $display("[FAIL] in_ready_o 0x%h with %0d packets held", $sampled(in_ready),
                $sampled(held));
        end

    ast_full_rate: assert property (@(posedge clk) disable iff (rst)
        thru_mode |-> in_ready)
        else begin
            errors++;
            $display("[FAIL] in_ready_o 0x%h while streaming at full rate", $sampled(in_ready));
        end

    task automatic stream(input int kind, input int n, input int vld_pct, input int rdy_pct);
        int sent;
        sent = 0;
        while (sent < n) begin
            @(posedge clk);
            if (in_valid && in_ready) begin
                sent++;
            end
            if (in_valid && !in_ready) begin
                in_valid <= 1'b1;   // word held until accepted
            end else if (sent < n && chance(vld_pct)) begin
                in_inst  <= gen_word(kind);
                in_valid <= 1'b1;
            end else begin
                in_valid <= 1'b0;
            end
            out_ready <= chance(rdy_pct);
        end
    endtask

    task automatic drain();
        @(posedge clk);
        in_valid  <= 1'b0;
        out_ready <= 1'b1;
        while (out_valid) begin
            @(posedge clk);
        end
    endtask

    task automatic run_test(input string name, input int kind, input int n,
                            input int vld_pct, input int rdy_pct);
        int err0;
        int acc0;
        err0 = errors;
        acc0 = accepted;
        stream(kind, n, vld_pct, rdy_pct);
        drain();
        tests++;
        $display("%-10s %0d words, %0d errors", name, accepted - acc0, errors - err0);
    endtask

    initial begin
        rng_state = 32'h853f_d223;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        repeat (2) @(posedge clk);
        tests++;
        $display("%-10s 0 words, %0d errors", "reset", errors);

        run_test("rv32i", K_RV32I, N_RV32I, 80, 100);
        run_test("rv32m_sys", K_MSYS, N_MSYS, 80, 100);
        run_test("dropped", K_DROP, N_DROP, 80, 100);
        run_test("backpress", K_MIX, N_PRESS, 70, 50);
        @(posedge clk);
        thru_mode <= 1'b1;
        run_test("full_rate", K_MIX, N_THRU, 100, 100);
        thru_mode <= 1'b0;
        @(posedge clk);

        assert (accepted == taken && held == 0)
            else begin
                errors++;
                $display("%0d words accepted but %0d packets taken", accepted, taken);
            end
        $display("%0d tests, %0d packets checked, %0d errors", tests, taken, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== idu.f ====
+incdir+bench
rtl/idu_pkg.sv
rtl/idu_class.sv
rtl/idu_func.sv
rtl/idu_imm.sv
rtl/idu_operand.sv
rtl/idu_out_buf.sv
rtl/idu_top.sv
bench/idu_tb.sv

// ==== run.sh ====
#!/bin/sh
# builds the decode stage testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

verilator --binary --timing --assert --top-module idu_tb -f idu.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/Vidu_tb 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx 'Test OK'; then
    exit 0
fi
exit 1
